// ==== src/pixel_pkg.sv ====
`default_nettype none

package pixel_pkg;

  localparam int word_width  = 8;
  localparam int rows        = 4;
  localparam int kh_max      = 3;
  localparam int edge_words  = kh_max / 2;
  localparam int col_words   = rows + edge_words;
  localparam int shift_words = rows + kh_max - 1;

  // Image geometry limits
  localparam int cin_max    = 4;
  localparam int cols_max   = 8;
  localparam int blocks_max = 4;
  localparam int ram_depth  = cin_max * cols_max;

  typedef logic [word_width-1:0] pixel_t;

  // Config fields, each count is stored minus one
  typedef logic [$clog2((kh_max+1)/2)-1:0] kh2_t;
  typedef logic [$clog2(cin_max)-1:0]      cin_t;
  typedef logic [$clog2(cols_max)-1:0]     col_t;
  typedef logic [$clog2(blocks_max)-1:0]   blk_t;

  // Kernel row index, 0 to 2*kh2
  typedef logic [$clog2(kh_max)-1:0] kh_t;

  typedef logic [$clog2(ram_depth)-1:0] ram_addr_t;

  typedef enum logic [1:0] {
    scan_config,
    scan_pass,
    scan_drain
  } scan_state_e;

endpackage

`default_nettype wire

// ==== src/column_beat_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface column_beat_if;

  logic col_valid;
  logic col_ready;
  logic col_last;
  pixel_pkg::pixel_t [pixel_pkg::col_words-1:0] col_data;

  modport packer (
    output col_valid,
    output col_last,
    output col_data,
    input  col_ready
  );

  modport shifter (
    input  col_valid,
    input  col_last,
    input  col_data,
    output col_ready
  );

endinterface

`default_nettype wire

// ==== src/column_packer.sv ====
`timescale 1ns/1ns
`default_nettype none

module column_packer (
  input  wire logic              aclk,
  input  wire logic              aresetn,
  input  wire logic              s_valid,
  input  wire logic              s_last,
  input  wire pixel_pkg::pixel_t s_data,
  input  wire logic              in_open,
  output logic                   s_ready,
  column_beat_if.packer          col
);

  logic [$clog2(pixel_pkg::col_words+1)-1:0] cnt_q;
  logic full;
  logic take;

  assign full          = (cnt_q == pixel_pkg::col_words);
  assign s_ready       = in_open && !full;
  assign take          = s_valid && s_ready;
  assign col.col_valid = full;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      cnt_q <= '0;
    end else if (full && col.col_ready) begin
      cnt_q <= '0;
    end else if (take) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // First word of the column ends up at index 0
  always_ff @(posedge aclk) begin
    if (take) begin
      col.col_data <= {s_data, col.col_data[pixel_pkg::col_words-1:1]};
      col.col_last <= s_last;
    end
  end

  a_col_hold : assert property (
    @(posedge aclk) disable iff (!aresetn)
    col.col_valid && !col.col_ready |=> col.col_valid && $stable(col.col_data)
  );

endmodule

`default_nettype wire

// ==== src/scan_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module scan_ctrl (
  input  wire logic              aclk,
  input  wire logic              aresetn,
  input  wire logic              s_valid,
  input  wire logic              s_ready,
  input  wire logic              s_last,
  input  wire pixel_pkg::pixel_t s_data,
  input  wire logic              m_ready,
  input  wire logic              m_valid,
  input  wire logic              m_last,
  input  wire logic              col_valid,
  output logic                   cfg_en,
  output logic                   shift_en,
  output logic                   copy_en,
  output logic                   first_blk,
  output logic                   last_blk,
  output logic                   last_col,
  output logic                   in_open,
  output pixel_pkg::kh2_t        ref_kh2
);

  pixel_pkg::scan_state_e state_q;

  pixel_pkg::kh2_t cfg_kh2;
  pixel_pkg::cin_t cfg_cin;
  pixel_pkg::col_t cfg_col;
  pixel_pkg::blk_t cfg_blk;

  pixel_pkg::cin_t ref_cin;
  pixel_pkg::col_t ref_col;
  pixel_pkg::blk_t ref_blk;

  pixel_pkg::kh_t  kh_q;
  pixel_pkg::kh_t  kh_max;
  pixel_pkg::cin_t cin_q;
  pixel_pkg::col_t col_q;
  pixel_pkg::blk_t blk_q;

  logic in_beat;
  logic in_last_beat;
  logic out_last_beat;
  logic kh_last;
  logic cin_last;
  logic col_end;

  // Config word packs kh2, cin-1, cols-1 and blocks-1 from bit 0 up
  assign {cfg_blk, cfg_col, cfg_cin, cfg_kh2} = s_data;

  assign in_beat       = s_valid && s_ready;
  assign in_last_beat  = in_beat && s_last;
  assign out_last_beat = m_valid && m_ready && m_last;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= pixel_pkg::scan_config;
    end else begin
      unique case (state_q)
        pixel_pkg::scan_config: begin
          if (in_beat) state_q <= pixel_pkg::scan_pass;
        end
        pixel_pkg::scan_pass: begin
          if (in_last_beat) state_q <= pixel_pkg::scan_drain;
        end
        pixel_pkg::scan_drain: begin
          if (out_last_beat) state_q <= pixel_pkg::scan_config;
        end
        default: state_q <= pixel_pkg::scan_config;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (cfg_en) begin
      ref_kh2 <= cfg_kh2;
      ref_cin <= cfg_cin;
      ref_col <= cfg_col;
      ref_blk <= cfg_blk;
    end
  end

  assign cfg_en    = (state_q == pixel_pkg::scan_config);
  assign in_open   = (state_q == pixel_pkg::scan_pass);
  assign shift_en  = m_ready && !cfg_en;

  assign kh_max    = pixel_pkg::kh_t'({ref_kh2, 1'b0});
  assign kh_last   = (kh_q == kh_max);
  assign cin_last  = (cin_q == ref_cin);
  assign col_end   = (col_q == ref_col);

  // Kernel row counter parks at its last count until a column is there
  assign copy_en   = shift_en && col_valid && kh_last;
  assign last_col  = copy_en && cin_last && col_end;
  assign first_blk = (blk_q == '0);
  assign last_blk  = (blk_q == ref_blk);

  always_ff @(posedge aclk) begin
    if (!aresetn || cfg_en) begin
      kh_q  <= pixel_pkg::kh_t'({cfg_kh2, 1'b0});
      cin_q <= '0;
      col_q <= '0;
      blk_q <= '0;
    end else begin
      if (copy_en) begin
        kh_q <= '0;
      end else if (shift_en && !kh_last) begin
        kh_q <= kh_q + 1'b1;
      end
      if (copy_en) begin
        cin_q <= cin_last ? '0 : cin_q + 1'b1;
      end
      if (copy_en && cin_last) begin
        col_q <= col_end ? '0 : col_q + 1'b1;
      end
      if (last_col) begin
        blk_q <= last_blk ? '0 : blk_q + 1'b1;
      end
    end
  end

  // No output beat is pending while waiting for a config beat
  a_idle_in_config : assert property (
    @(posedge aclk) disable iff (!aresetn)
    cfg_en |-> !m_valid
  );

endmodule

`default_nettype wire

// ==== src/edge_line_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module edge_line_ram (
  input  wire logic              aclk,
  input  wire logic              cfg_en,
  input  wire logic              last_col,
  input  wire logic              copy_en,
  input  wire logic              hold,
  input  wire logic              rd_en,
  input  wire logic              wr_en,
  input  wire pixel_pkg::pixel_t wr_data,
  output pixel_pkg::pixel_t      rd_data
);

  pixel_pkg::pixel_t mem [pixel_pkg::ram_depth];

  pixel_pkg::ram_addr_t addr_q;
  pixel_pkg::ram_addr_t wr_addr_q;

  // One entry per column and channel, restarting every block
  always_ff @(posedge aclk) begin
    if (cfg_en || last_col) begin
      addr_q <= '0;
    end else if (copy_en) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  // Follows the stage register of the shifter
  always_ff @(posedge aclk) begin
    if (!hold) begin
      wr_addr_q <= addr_q;
    end
  end

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_addr_q] <= wr_data;
    end
  end

  // Bypass covers a block of a single column and channel
  always_ff @(posedge aclk) begin
    if (copy_en && rd_en) begin
      rd_data <= (wr_en && wr_addr_q == addr_q) ? wr_data : mem[addr_q];
    end
  end

endmodule

`default_nettype wire

// ==== src/window_shifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module window_shifter (
  input  wire logic                                aclk,
  input  wire logic                                aresetn,
  input  wire logic                                shift_en,
  input  wire logic                                copy_en,
  input  wire logic                                first_blk,
  input  wire logic                                last_blk,
  input  wire pixel_pkg::kh2_t                     ref_kh2,
  column_beat_if.shifter                           col,
  input  wire pixel_pkg::pixel_t                   ram_rd_data,
  output pixel_pkg::pixel_t                        ram_wr_data,
  output logic                                     m_valid,
  output logic                                     m_last,
  output pixel_pkg::pixel_t [pixel_pkg::rows-1:0]  m_data,
  output logic                                     ram_wr_en
);

  pixel_pkg::pixel_t [pixel_pkg::col_words-1:0]   stg_data;
  pixel_pkg::pixel_t [pixel_pkg::shift_words-1:0] shift_q;
  pixel_pkg::pixel_t                              halo;
  pixel_pkg::kh_t                                 beat_q;

  logic stg_copy;
  logic stg_last;
  logic stg_first;
  logic stg_last_blk;
  logic out_last;
  logic load;
  logic final_beat;

  assign col.col_ready = copy_en;

  // Stage register, lines up with the RAM read latency
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      stg_copy <= 1'b0;
    end else if (shift_en) begin
      stg_copy <= copy_en;
    end
  end

  always_ff @(posedge aclk) begin
    if (shift_en) begin
      stg_data     <= col.col_data;
      stg_last     <= col.col_last;
      stg_first    <= first_blk;
      stg_last_blk <= last_blk;
    end
  end

  assign load        = shift_en && stg_copy;
  assign halo        = stg_first ? '0 : ram_rd_data;
  assign ram_wr_en   = load && !stg_last_blk;
  assign ram_wr_data = stg_data[pixel_pkg::rows-1];

  always_ff @(posedge aclk) begin
    if (load) begin
      shift_q <= {stg_data, halo};
    end else if (shift_en) begin
      shift_q <= shift_q >> pixel_pkg::word_width;
    end
  end

  // Beat index within the current column
  assign final_beat = (beat_q == pixel_pkg::kh_t'({ref_kh2, 1'b0}));

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      m_valid  <= 1'b0;
      out_last <= 1'b0;
      beat_q   <= '0;
    end else if (shift_en) begin
      if (load) begin
        m_valid  <= 1'b1;
        out_last <= stg_last;
        beat_q   <= '0;
      end else begin
        if (final_beat) m_valid <= 1'b0;
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  assign m_last = m_valid && out_last && final_beat;

  always_comb begin
    for (int r = 0; r < pixel_pkg::rows; r++) begin
      m_data[r] = shift_q[r + pixel_pkg::edge_words - ref_kh2];
    end
  end

  // A new column never cuts the previous one short
  a_load_on_free : assert property (
    @(posedge aclk) disable iff (!aresetn)
    load |-> !m_valid || final_beat
  );

endmodule

`default_nettype wire

// ==== src/pixel_feeder_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixel_feeder_top (
  input  wire logic                               aclk,
  input  wire logic                               aresetn,
  input  wire logic                               s_valid,
  output logic                                    s_ready,
  input  wire logic                               s_last,
  input  wire pixel_pkg::pixel_t                  s_data,
  output logic                                    m_valid,
  input  wire logic                               m_ready,
  output logic                                    m_last,
  output pixel_pkg::pixel_t [pixel_pkg::rows-1:0] m_data
);

  logic pk_ready;
  logic cfg_en;
  logic shift_en;
  logic copy_en;
  logic first_blk;
  logic last_blk;
  logic last_col;
  logic in_open;
  logic ram_wr_en;

  pixel_pkg::kh2_t   ref_kh2;
  pixel_pkg::pixel_t ram_rd_data;
  pixel_pkg::pixel_t ram_wr_data;

  column_beat_if col_if ();

  // The config beat goes to the controller, pixels to the packer
  assign s_ready = cfg_en || pk_ready;

  column_packer u_column_packer (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_valid),
    .s_last  (s_last),
    .s_data  (s_data),
    .in_open (in_open),
    .s_ready (pk_ready),
    .col     (col_if.packer)
  );

  scan_ctrl u_scan_ctrl (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .s_last    (s_last),
    .s_data    (s_data),
    .m_ready   (m_ready),
    .m_valid   (m_valid),
    .m_last    (m_last),
    .col_valid (col_if.col_valid),
    .cfg_en    (cfg_en),
    .shift_en  (shift_en),
    .copy_en   (copy_en),
    .first_blk (first_blk),
    .last_blk  (last_blk),
    .last_col  (last_col),
    .in_open   (in_open),
    .ref_kh2   (ref_kh2)
  );

  edge_line_ram u_edge_line_ram (
    .aclk     (aclk),
    .cfg_en   (cfg_en),
    .last_col (last_col),
    .copy_en  (copy_en),
    .hold     (!shift_en),
    .rd_en    (!first_blk),
    .wr_en    (ram_wr_en),
    .wr_data  (ram_wr_data),
    .rd_data  (ram_rd_data)
  );

  window_shifter u_window_shifter (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .shift_en    (shift_en),
    .copy_en     (copy_en),
    .first_blk   (first_blk),
    .last_blk    (last_blk),
    .ref_kh2     (ref_kh2),
    .col         (col_if.shifter),
    .ram_rd_data (ram_rd_data),
    .ram_wr_data (ram_wr_data),
    .m_valid     (m_valid),
    .m_last      (m_last),
    .m_data      (m_data),
    .ram_wr_en   (ram_wr_en)
  );

endmodule

`default_nettype wire

// ==== verification/pixel_feeder_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixel_feeder_tb;

  localparam int out_bits = pixel_pkg::rows * pixel_pkg::word_width;

  logic aclk;
  logic aresetn;
  logic s_valid;
  logic s_ready;
  logic s_last;
  logic m_valid;
  logic m_ready;
  logic m_last;
  pixel_pkg::pixel_t s_data;
  pixel_pkg::pixel_t [pixel_pkg::rows-1:0] m_data;

  // Input words of one image, indexed block, column, channel, row
  pixel_pkg::pixel_t img [pixel_pkg::blocks_max][pixel_pkg::cols_max]
                         [pixel_pkg::cin_max][pixel_pkg::col_words];

  logic [out_bits-1:0] exp_data [$];
  logic                exp_last [$];

  integer seed = 18315;
  int err_count = 0;
  int check_count = 0;
  int cycles = 0;
  int deadline = 200;

  pixel_feeder_top u_pixel_feeder_top (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_last  (s_last),
    .s_data  (s_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_last  (m_last),
    .m_data  (m_data)
  );

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  always @(posedge aclk) begin
    cycles <= cycles + 1;
  end

  task automatic check_value(input string name, input logic [out_bits-1:0] got,
                             input logic [out_bits-1:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic fill_image(input int cin, input int cols, input int blocks);
    for (int b = 0; b < blocks; b++) begin
      for (int c = 0; c < cols; c++) begin
        for (int ch = 0; ch < cin; ch++) begin
          for (int w = 0; w < pixel_pkg::col_words; w++) begin
            img[b][c][ch][w] = pixel_pkg::pixel_t'($random(seed));
          end
        end
      end
    end
  endtask

  // Window rows come from the halo word followed by the column words
  task automatic build_expected(input int kh2, input int cin, input int cols,
                                input int blocks);
    pixel_pkg::pixel_t v [pixel_pkg::col_words+1];
    logic [out_bits-1:0] beat;
    exp_data.delete();
    exp_last.delete();
    for (int b = 0; b < blocks; b++) begin
      for (int c = 0; c < cols; c++) begin
        for (int ch = 0; ch < cin; ch++) begin
          v[0] = (b == 0) ? '0 : img[b-1][c][ch][pixel_pkg::rows-1];
          for (int w = 0; w < pixel_pkg::col_words; w++) begin
            v[w+1] = img[b][c][ch][w];
          end
          for (int k = 0; k <= 2 * kh2; k++) begin
            for (int r = 0; r < pixel_pkg::rows; r++) begin
              beat[r*pixel_pkg::word_width +: pixel_pkg::word_width] = v[r+k+1-kh2];
            end
            exp_data.push_back(beat);
            exp_last.push_back(b == blocks - 1 && c == cols - 1 && ch == cin - 1 &&
                               k == 2 * kh2);
          end
        end
      end
    end
  endtask

  // Called at a falling edge, returns at the falling edge after the handshake
  task automatic send_word(input pixel_pkg::pixel_t d, input logic last, input bit gaps);
    int idle;
    logic done;
    idle = gaps ? ($random(seed) & 3) : 0;
    repeat (idle) @(negedge aclk);
    s_valid = 1'b1;
    s_data = d;
    s_last = last;
    done = 1'b0;
    while (!done) begin
      done = s_ready;
      @(negedge aclk);
    end
    s_valid = 1'b0;
    s_last = 1'b0;
  endtask

  task automatic send_image(input int kh2, input int cin, input int cols,
                            input int blocks, input bit gaps);
    pixel_pkg::pixel_t cfg;
    logic last;
    cfg = {pixel_pkg::blk_t'(blocks - 1), pixel_pkg::col_t'(cols - 1),
           pixel_pkg::cin_t'(cin - 1), pixel_pkg::kh2_t'(kh2)};
    send_word(cfg, 1'b0, gaps);
    for (int b = 0; b < blocks; b++) begin
      for (int c = 0; c < cols; c++) begin
        for (int ch = 0; ch < cin; ch++) begin
          for (int w = 0; w < pixel_pkg::col_words; w++) begin
            last = (b == blocks - 1 && c == cols - 1 && ch == cin - 1 &&
                    w == pixel_pkg::col_words - 1);
            send_word(img[b][c][ch][w], last, gaps);
          end
        end
      end
    end
  endtask

  task automatic collect_output(input bit backpressure);
    logic [out_bits-1:0] exp_beat;
    logic exp_l;
    while (exp_data.size() != 0) begin
      @(negedge aclk);
      m_ready = backpressure ? (($random(seed) & 3) != 0) : 1'b1;
      if (m_valid && m_ready) begin
        exp_beat = exp_data.pop_front();
        exp_l = exp_last.pop_front();
        check_value("m_data", m_data, exp_beat);
        check_value("m_last", m_last, exp_l);
      end
    end
  endtask

  task automatic run_image(input int kh2, input int cin, input int cols, input int blocks,
                           input bit backpressure, input bit gaps);
    fill_image(cin, cols, blocks);
    build_expected(kh2, cin, cols, blocks);
    deadline = cycles + 40 * exp_data.size() + 200;
    fork
      send_image(kh2, cin, cols, blocks, gaps);
      collect_output(backpressure);
    join
    // Back in config with nothing left on the output
    @(negedge aclk);
    check_value("s_ready", s_ready, 1);
    check_value("m_valid", m_valid, 0);
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    $display("test %0d %s: %0d errors", num, name, err_count - errs_before);
  endtask

  task automatic test_single_block();
    int errs;
    errs = err_count;
    run_image(0, 1, 2, 1, 1'b0, 1'b0);
    report_test(1, "single block kh2=0", errs);
  endtask

  task automatic test_halo_blocks();
    int errs;
    errs = err_count;
    run_image(1, 2, 2, 3, 1'b0, 1'b0);
    report_test(2, "three blocks with halo", errs);
  endtask

  task automatic test_output_backpressure();
    int errs;
    errs = err_count;
    run_image(1, 2, 2, 3, 1'b1, 1'b0);
    report_test(3, "output back-pressure", errs);
  endtask

  task automatic test_input_gaps();
    int errs;
    errs = err_count;
    run_image(1, 2, 2, 3, 1'b0, 1'b1);
    report_test(4, "input gaps", errs);
  endtask

  task automatic test_back_to_back();
    int errs;
    errs = err_count;
    run_image(1, 1, 3, 2, 1'b0, 1'b0);
    run_image(0, 3, 1, 3, 1'b1, 1'b1);
    report_test(5, "two images back to back", errs);
  endtask

  initial begin : watchdog
    while (cycles <= deadline) @(posedge aclk);
    $display("Timeout after %0d cycles, the DUT stopped moving data", cycles);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    aresetn = 1'b0;
    s_valid = 1'b0;
    s_last = 1'b0;
    s_data = '0;
    m_ready = 1'b0;
    repeat (3) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;

    test_single_block();
    test_halo_blocks();
    test_output_backpressure();
    test_input_gaps();
    test_back_to_back();

    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== pixel_feeder_top.f ====
src/pixel_pkg.sv
src/column_beat_if.sv
src/column_packer.sv
src/scan_ctrl.sv
src/edge_line_ram.sv
src/window_shifter.sv
src/pixel_feeder_top.sv
verification/pixel_feeder_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the pixel feeder testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f pixel_feeder_top.f \
  --top-module pixel_feeder_tb \
  -o pixel_feeder_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/pixel_feeder_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
